// ==== src/cluster_pkg.sv ====
package cluster_pkg;

    // address and data widths of the read ports
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    // burst length minus one, axi style
    typedef logic [3:0]  len_t;
    typedef logic [3:0]  node_id_t;
    typedef logic [1:0]  resp_t;

    // apb config port
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // 64 bit beats
    localparam int unsigned BEAT_BYTES = 8;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } dma_desc_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } ar_req_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
    } r_beat_t;

    typedef struct packed {
        data_t    data;
        node_id_t src;
        logic     last;
    } flit_t;

    // per channel register map, channel 1 sits one stride higher
    localparam apb_addr_t REG_SRC    = 12'h000;
    localparam apb_addr_t REG_LEN    = 12'h004;
    localparam apb_addr_t REG_CTRL   = 12'h008;
    localparam apb_addr_t REG_STATUS = 12'h00C;
    localparam apb_addr_t CH_STRIDE  = 12'h010;

    // bit positions in ctrl and status
    localparam int unsigned CTRL_START = 0;
    localparam int unsigned STAT_BUSY  = 0;
    localparam int unsigned STAT_DONE  = 1;
    localparam int unsigned STAT_ERR   = 2;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_ADDR,
        DMA_DATA
    } dma_state_e;

endpackage

// ==== src/apb_dma_regs.sv ====
module apb_dma_regs (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  cluster_pkg::apb_addr_t       paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  cluster_pkg::apb_data_t       pwdata_i,
    output cluster_pkg::apb_data_t       prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    output cluster_pkg::dma_desc_t [1:0] desc_o,
    output logic [1:0]                   desc_valid_o,
    input  logic [1:0]                   desc_ready_i,
    input  logic [1:0]                   done_i,
    input  logic [1:0]                   error_i,
    output logic                         irq_o
);
    import cluster_pkg::*;

    // software visible config
    addr_t [1:0]     src_q;
    len_t [1:0]      len_q;
    // descriptor snapshot taken at start
    dma_desc_t [1:0] desc_q;
    logic [1:0]      desc_valid_q;
    // status bits
    logic [1:0]      busy_q;
    logic [1:0]      done_q;
    logic [1:0]      err_q;

    // decoded access
    apb_addr_t       off;
    logic            ch;
    logic            mapped;
    logic            access;
    logic            start_wr;
    logic            bad_start;
    logic [1:0]      wr_sel;

    // split address into channel and register offset
    always_comb begin
        ch  = 1'b0;
        off = paddr_i;
        if (paddr_i >= CH_STRIDE) begin
            ch  = 1'b1;
            off = paddr_i - CH_STRIDE;
        end
        mapped = (paddr_i < 2 * CH_STRIDE) &&
                 (off == REG_SRC || off == REG_LEN || off == REG_CTRL || off == REG_STATUS);
    end

    // no wait states, ready in every access phase
    assign access    = psel_i & penable_i;
    assign pready_o  = access;
    assign start_wr  = access & pwrite_i & mapped & (off == REG_CTRL) & pwdata_i[CTRL_START];
    // start on a running channel is refused
    assign bad_start = start_wr & busy_q[ch];
    assign pslverr_o = access & (~mapped | bad_start);
    // one-hot write enable, faulty writes dropped
    assign wr_sel    = (access & pwrite_i & mapped & ~bad_start) ? (2'b01 << ch) : 2'b00;

    // read mux, zero for unmapped
    always_comb begin
        prdata_o = '0;
        if (mapped) begin
            case (off)
                REG_SRC:    prdata_o = src_q[ch];
                REG_LEN:    prdata_o[$bits(len_t)-1:0] = len_q[ch];
                REG_STATUS: begin
                    prdata_o[STAT_BUSY] = busy_q[ch];
                    prdata_o[STAT_DONE] = done_q[ch];
                    prdata_o[STAT_ERR]  = err_q[ch];
                end
                default:    prdata_o = '0;
            endcase
        end
    end

    // config and descriptor payload
    always_ff @(posedge clk_i) begin
        for (int c = 0; c < 2; c++) begin
            if (wr_sel[c]) begin
                case (off)
                    REG_SRC:  src_q[c] <= pwdata_i;
                    REG_LEN:  len_q[c] <= pwdata_i[$bits(len_t)-1:0];
                    REG_CTRL: begin
                        if (pwdata_i[CTRL_START]) begin
                            desc_q[c].addr <= src_q[c];
                            desc_q[c].len  <= len_q[c];
                        end
                    end
                    default:  ;
                endcase
            end
        end
    end

    // descriptor handshake and sticky status
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            desc_valid_q <= '0;
            busy_q       <= '0;
            done_q       <= '0;
            err_q        <= '0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (desc_valid_q[c] && desc_ready_i[c]) begin
                    desc_valid_q[c] <= 1'b0;
                end
                // write one to done clears done and error
                if (wr_sel[c] && off == REG_STATUS && pwdata_i[STAT_DONE]) begin
                    done_q[c] <= 1'b0;
                    err_q[c]  <= 1'b0;
                end
                if (wr_sel[c] && off == REG_CTRL && pwdata_i[CTRL_START]) begin
                    desc_valid_q[c] <= 1'b1;
                    busy_q[c]       <= 1'b1;
                end
                // channel events win over a clear in the same cycle
                if (done_i[c]) begin
                    busy_q[c] <= 1'b0;
                    done_q[c] <= 1'b1;
                end
                if (error_i[c]) begin
                    err_q[c] <= 1'b1;
                end
            end
        end
    end

    assign desc_o       = desc_q;
    assign desc_valid_o = desc_valid_q;
    // level irq while any done is pending
    assign irq_o        = |done_q;

endmodule

// ==== src/data_dma_channel.sv ====
module data_dma_channel #(
    parameter cluster_pkg::node_id_t NODE_ID = 4'd12
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // descriptor from the register file
    input  cluster_pkg::dma_desc_t desc_i,
    input  logic                  desc_valid_i,
    output logic                  desc_ready_o,
    // read address
    output cluster_pkg::ar_req_t  ar_o,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    // read data
    input  cluster_pkg::r_beat_t  r_i,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    // flits toward the merge
    output cluster_pkg::flit_t    flit_o,
    output logic                  flit_valid_o,
    input  logic                  flit_ready_i,
    output logic                  done_o,
    output logic                  error_o
);
    import cluster_pkg::*;

    dma_state_e state_q;
    dma_desc_t  desc_q;
    len_t       beat_cnt_q;
    // any bad resp seen in this burst
    logic       err_acc_q;
    logic       done_q;
    logic       error_q;

    logic       beat_xfer;
    logic       beat_last;
    logic       beat_err;

    // accept a descriptor only when idle
    assign desc_ready_o = (state_q == DMA_IDLE);

    // one burst per descriptor
    assign ar_valid_o = (state_q == DMA_ADDR);
    assign ar_o.addr  = desc_q.addr;
    assign ar_o.len   = desc_q.len;

    // beats pass straight through, flit backpressure stalls r
    assign flit_valid_o = (state_q == DMA_DATA) & r_valid_i;
    assign r_ready_o    = (state_q == DMA_DATA) & flit_ready_i;
    assign beat_xfer    = flit_valid_o & flit_ready_i;
    // last comes from the beat count, rlast is not trusted
    assign beat_last    = (beat_cnt_q == desc_q.len);
    // anything but okay counts as an error
    assign beat_err     = (r_i.resp != '0);

    assign flit_o.data = r_i.data;
    assign flit_o.src  = NODE_ID;
    assign flit_o.last = beat_last;

    assign done_o  = done_q;
    assign error_o = error_q;

    // descriptor latch
    always_ff @(posedge clk_i) begin
        if (desc_ready_o && desc_valid_i) begin
            desc_q <= desc_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= DMA_IDLE;
            beat_cnt_q <= '0;
            err_acc_q  <= 1'b0;
            done_q     <= 1'b0;
            error_q    <= 1'b0;
        end else begin
            // completion outputs are single cycle pulses
            done_q  <= 1'b0;
            error_q <= 1'b0;
            case (state_q)
                DMA_IDLE: begin
                    if (desc_valid_i) begin
                        state_q    <= DMA_ADDR;
                        beat_cnt_q <= '0;
                        err_acc_q  <= 1'b0;
                    end
                end
                DMA_ADDR: begin
                    if (ar_ready_i) begin
                        state_q <= DMA_DATA;
                    end
                end
                DMA_DATA: begin
                    if (beat_xfer) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (beat_err) begin
                            err_acc_q <= 1'b1;
                        end
                        // report done and error together after the final beat
                        if (beat_last) begin
                            state_q <= DMA_IDLE;
                            done_q  <= 1'b1;
                            error_q <= err_acc_q | beat_err;
                        end
                    end
                end
                default: state_q <= DMA_IDLE;
            endcase
        end
    end

endmodule

// ==== src/flit_merge.sv ====
module flit_merge (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  cluster_pkg::flit_t [1:0] in_i,
    input  logic [1:0]               in_valid_i,
    output logic [1:0]               in_ready_o,
    output cluster_pkg::flit_t       out_o,
    output logic                     out_valid_o,
    input  logic                     out_ready_i
);
    import cluster_pkg::*;

    // one entry output stage
    flit_t out_q;
    logic  out_valid_q;
    // grant held mid packet
    logic  lock_q;
    logic  cur_q;
    // round robin pointer, next preferred input
    logic  rr_q;

    logic  sel;
    logic  space;
    logic  take;

    always_comb begin
        // locked grant first, then rr with fallback to the other input
        if (lock_q) begin
            sel = cur_q;
        end else if (in_valid_i[rr_q]) begin
            sel = rr_q;
        end else begin
            sel = ~rr_q;
        end
        // register frees up in the same cycle its flit leaves
        space      = ~out_valid_q | out_ready_i;
        in_ready_o = space ? (2'b01 << sel) : 2'b00;
        take       = space & in_valid_i[sel];
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            out_q <= in_i[sel];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q <= 1'b0;
            lock_q      <= 1'b0;
            cur_q       <= 1'b0;
            rr_q        <= 1'b0;
        end else begin
            if (take) begin
                out_valid_q <= 1'b1;
                cur_q       <= sel;
                lock_q      <= ~in_i[sel].last;
                // packet done, hand priority to the other side
                if (in_i[sel].last) begin
                    rr_q <= ~sel;
                end
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    assign out_o       = out_q;
    assign out_valid_o = out_valid_q;

endmodule

// ==== src/dma_cluster_top.sv ====
module dma_cluster_top #(
    parameter cluster_pkg::node_id_t NODE_ID0 = 4'd12,
    parameter cluster_pkg::node_id_t NODE_ID1 = 4'd15
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    // apb slave
    input  cluster_pkg::apb_addr_t paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  cluster_pkg::apb_data_t pwdata_i,
    output cluster_pkg::apb_data_t prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    // read port of channel 0
    output cluster_pkg::ar_req_t   ar0_o,
    output logic                   ar0_valid_o,
    input  logic                   ar0_ready_i,
    input  cluster_pkg::r_beat_t   r0_i,
    input  logic                   r0_valid_i,
    output logic                   r0_ready_o,
    // read port of channel 1
    output cluster_pkg::ar_req_t   ar1_o,
    output logic                   ar1_valid_o,
    input  logic                   ar1_ready_i,
    input  cluster_pkg::r_beat_t   r1_i,
    input  logic                   r1_valid_i,
    output logic                   r1_ready_o,
    // network output
    output cluster_pkg::flit_t     flit_o,
    output logic                   flit_valid_o,
    input  logic                   flit_ready_i,
    output logic                   irq_o
);
    import cluster_pkg::*;

    // descriptors from the register file
    dma_desc_t [1:0] desc;
    logic [1:0]      desc_valid;
    logic [1:0]      desc_ready;
    // completion pulses back
    logic [1:0]      done;
    logic [1:0]      error;
    // channel flit streams into the merge
    flit_t [1:0]     ch_flit;
    logic [1:0]      ch_flit_valid;
    logic [1:0]      ch_flit_ready;

    apb_dma_regs apb_dma_regs_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .desc_o       (desc),
        .desc_valid_o (desc_valid),
        .desc_ready_i (desc_ready),
        .done_i       (done),
        .error_i      (error),
        .irq_o        (irq_o)
    );

    data_dma_channel #(
        .NODE_ID (NODE_ID0)
    ) data_dma_channel0_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .desc_i       (desc[0]),
        .desc_valid_i (desc_valid[0]),
        .desc_ready_o (desc_ready[0]),
        .ar_o         (ar0_o),
        .ar_valid_o   (ar0_valid_o),
        .ar_ready_i   (ar0_ready_i),
        .r_i          (r0_i),
        .r_valid_i    (r0_valid_i),
        .r_ready_o    (r0_ready_o),
        .flit_o       (ch_flit[0]),
        .flit_valid_o (ch_flit_valid[0]),
        .flit_ready_i (ch_flit_ready[0]),
        .done_o       (done[0]),
        .error_o      (error[0])
    );

    data_dma_channel #(
        .NODE_ID (NODE_ID1)
    ) data_dma_channel1_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .desc_i       (desc[1]),
        .desc_valid_i (desc_valid[1]),
        .desc_ready_o (desc_ready[1]),
        .ar_o         (ar1_o),
        .ar_valid_o   (ar1_valid_o),
        .ar_ready_i   (ar1_ready_i),
        .r_i          (r1_i),
        .r_valid_i    (r1_valid_i),
        .r_ready_o    (r1_ready_o),
        .flit_o       (ch_flit[1]),
        .flit_valid_o (ch_flit_valid[1]),
        .flit_ready_i (ch_flit_ready[1]),
        .done_o       (done[1]),
        .error_o      (error[1])
    );

    flit_merge flit_merge_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_i        (ch_flit),
        .in_valid_i  (ch_flit_valid),
        .in_ready_o  (ch_flit_ready),
        .out_o       (flit_o),
        .out_valid_o (flit_valid_o),
        .out_ready_i (flit_ready_i)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset held low for a fixed number of cycles
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

// ==== test/dma_cluster_asserts.sv ====
module dma_cluster_asserts (
    input logic                 clk_i,
    input logic                 arst_n_i,
    input cluster_pkg::ar_req_t ar0_o,
    input logic                 ar0_valid_o,
    input logic                 ar0_ready_i,
    input cluster_pkg::r_beat_t r0_i,
    input logic                 r0_valid_i,
    input logic                 r0_ready_o,
    input cluster_pkg::ar_req_t ar1_o,
    input logic                 ar1_valid_o,
    input logic                 ar1_ready_i,
    input cluster_pkg::r_beat_t r1_i,
    input logic                 r1_valid_i,
    input logic                 r1_ready_o,
    input cluster_pkg::flit_t   flit_o,
    input logic                 flit_valid_o,
    input logic                 flit_ready_i,
    input logic                 irq_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import cluster_pkg::*;

    // burst length and beat count per read port
    len_t     len0_q;
    len_t     len1_q;
    len_t     cnt0_q;
    len_t     cnt1_q;
    // source of the packet on the network port
    logic     in_pkt_q;
    node_id_t pkt_src_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            len0_q   <= '0;
            len1_q   <= '0;
            cnt0_q   <= '0;
            cnt1_q   <= '0;
            in_pkt_q <= 1'b0;
            pkt_src_q <= '0;
        end else begin
            if (ar0_valid_o && ar0_ready_i) begin
                len0_q <= ar0_o.len;
                cnt0_q <= '0;
            end else if (r0_valid_i && r0_ready_o) begin
                cnt0_q <= cnt0_q + 1'b1;
            end
            if (ar1_valid_o && ar1_ready_i) begin
                len1_q <= ar1_o.len;
                cnt1_q <= '0;
            end else if (r1_valid_i && r1_ready_o) begin
                cnt1_q <= cnt1_q + 1'b1;
            end
            if (flit_valid_o && flit_ready_i) begin
                in_pkt_q  <= ~flit_o.last;
                pkt_src_q <= flit_o.src;
            end
        end
    end

    // payload held while stalled
    ar0_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ar0_valid_o && !ar0_ready_i |=> ar0_valid_o && $stable(ar0_o))
        else $error("ar0 changed while stalled");
    ar1_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ar1_valid_o && !ar1_ready_i |=> ar1_valid_o && $stable(ar1_o))
        else $error("ar1 changed while stalled");
    r0_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r0_valid_i && !r0_ready_o |=> r0_valid_i && $stable(r0_i))
        else $error("r0 changed while stalled");
    r1_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r1_valid_i && !r1_ready_o |=> r1_valid_i && $stable(r1_i))
        else $error("r1 changed while stalled");
    flit_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        flit_valid_o && !flit_ready_i |=> flit_valid_o && $stable(flit_o))
        else $error("flit changed while stalled");

    irq_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !irq_o)
        else $error("irq high during reset");

    // no interleaving of packets
    src_in_packet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        flit_valid_o && in_pkt_q |-> flit_o.src == pkt_src_q)
        else $error("packet interrupted by another source");

    rlast0_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r0_valid_i && r0_ready_o |-> r0_i.last == (cnt0_q == len0_q))
        else $error("rlast on port 0 disagrees with beat count");
    rlast1_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        r1_valid_i && r1_ready_o |-> r1_i.last == (cnt1_q == len1_q))
        else $error("rlast on port 1 disagrees with beat count");

endmodule

bind dma_cluster_top dma_cluster_asserts dma_cluster_asserts_i (.*);

// ==== test/tb_dma_cluster.sv ====
module tb_dma_cluster;
    timeunit 1ns;
    timeprecision 100ps;
    import cluster_pkg::*;

    localparam node_id_t NODE_ID0 = 4'd12;
    localparam node_id_t NODE_ID1 = 4'd15;
    localparam int N_CONC = 18;
    // 40 bursts of up to 16 beats, about 6 cycles per beat with stalls and polling
    localparam int TIMEOUT_CYCLES = 40 * 16 * 6 + 160;

    logic        clk;
    logic        arst_n;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    ar_req_t     ar [2];
    logic [1:0]  ar_valid;
    logic [1:0]  ar_ready;
    r_beat_t     r_beat [2];
    logic [1:0]  r_valid;
    logic [1:0]  r_ready;
    flit_t       flit;
    logic        flit_valid;
    logic        flit_ready;
    logic        irq;

    integer      seed = 32'hab6a_54ad;
    int          cycle_cnt;
    // expected flits per channel
    flit_t       exp_q [2][$];
    // memory responder state
    logic [1:0]  rd_active;
    addr_t       rd_base [2];
    len_t        rd_len [2];
    int          rd_beat [2];
    int          err_beat [2];

    tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(16)) tb_clk_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    dma_cluster_top #(.NODE_ID0(NODE_ID0), .NODE_ID1(NODE_ID1)) dma_cluster_top_i (
        .clk_i (clk), .arst_n_i (arst_n),
        .paddr_i (paddr), .psel_i (psel), .penable_i (penable),
        .pwrite_i (pwrite), .pwdata_i (pwdata),
        .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
        .ar0_o (ar[0]), .ar0_valid_o (ar_valid[0]), .ar0_ready_i (ar_ready[0]),
        .r0_i (r_beat[0]), .r0_valid_i (r_valid[0]), .r0_ready_o (r_ready[0]),
        .ar1_o (ar[1]), .ar1_valid_o (ar_valid[1]), .ar1_ready_i (ar_ready[1]),
        .r1_i (r_beat[1]), .r1_valid_i (r_valid[1]), .r1_ready_o (r_ready[1]),
        .flit_o (flit), .flit_valid_o (flit_valid), .flit_ready_i (flit_ready),
        .irq_o (irq)
    );

    // memory pattern, depends on every address bit
    function automatic data_t mem_data(input addr_t a);
        return {a, a ^ 32'h5a5a_5a5a};
    endfunction

    task automatic stop_with_fail();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_fail();
        end
    endtask

    // one apb transfer, setup then access, sampled mid access
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        assert (pready) else begin
            $display("pready low in access phase");
            stop_with_fail();
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input apb_data_t wdata, input logic exp_err);
        apb_data_t rd;
        logic      err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        check_eq("pslverr_o", 64'(err), 64'(exp_err));
    endtask

    task automatic reg_read(input apb_addr_t addr, output apb_data_t rdata);
        logic err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_eq("pslverr_o", 64'(err), 64'h0);
    endtask

    // program and start one channel, queue its expected flits
    task automatic start_dma(input int ch, input addr_t src, input len_t len);
        apb_addr_t base;
        flit_t     f;
        base = (ch == 1) ? CH_STRIDE : 12'h000;
        reg_write(base + REG_SRC, src, 1'b0);
        reg_write(base + REG_LEN, 32'(len), 1'b0);
        for (int k = 0; k <= int'(len); k++) begin
            f.data = mem_data(src + addr_t'(k * 8));
            f.src  = (ch == 1) ? NODE_ID1 : NODE_ID0;
            f.last = (k == int'(len));
            exp_q[ch].push_back(f);
        end
        reg_write(base + REG_CTRL, 32'h1, 1'b0);
    endtask

    // poll status until done, then check the final status word
    task automatic wait_done(input int ch, input apb_data_t exp_status);
        apb_addr_t base;
        apb_data_t st;
        base = (ch == 1) ? CH_STRIDE : 12'h000;
        st   = '0;
        while (!st[STAT_DONE]) begin
            reg_read(base + REG_STATUS, st);
        end
        check_eq("prdata_o", 64'(st), 64'(exp_status));
        check_eq("irq_o", 64'(irq), 64'h1);
    endtask

    task automatic wait_drained();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(posedge clk);
        end
    endtask

    function automatic addr_t rand_addr();
        addr_t a;
        a = $random(seed);
        return {a[31:3], 3'b000};
    endfunction

    // read port responder, flit sink and flit checker
    always @(posedge clk) begin : model
        logic [31:0] rnd;
        logic        sent;
        flit_t       e;
        int          c_idx;
        if (arst_n) begin
            for (int c = 0; c < 2; c++) begin
                rnd = $random(seed);
                ar_ready[c] <= rnd[0] | rnd[1];
                if (ar_valid[c] && ar_ready[c]) begin
                    rd_active[c] = 1'b1;
                    rd_base[c]   = ar[c].addr;
                    rd_len[c]    = ar[c].len;
                    rd_beat[c]   = 0;
                end
                sent = r_valid[c] & r_ready[c];
                if (sent) begin
                    if (rd_beat[c] == int'(rd_len[c])) begin
                        rd_active[c] = 1'b0;
                    end
                    rd_beat[c]++;
                end
                if (!r_valid[c] || sent) begin
                    if (rd_active[c] && (rnd[2] | rnd[3])) begin
                        r_valid[c]     <= 1'b1;
                        r_beat[c].data <= mem_data(rd_base[c] + addr_t'(rd_beat[c] * 8));
                        r_beat[c].resp <= (rd_beat[c] == err_beat[c]) ? 2'b10 : 2'b00;
                        r_beat[c].last <= (rd_beat[c] == int'(rd_len[c]));
                    end else begin
                        r_valid[c] <= 1'b0;
                    end
                end
            end
            if (flit_valid && flit_ready) begin
                assert (flit.src == NODE_ID0 || flit.src == NODE_ID1) else begin
                    $display("** Error flit_o.src: got 0x%h, expected 0x%h or 0x%h",
                             flit.src, NODE_ID0, NODE_ID1);
                    stop_with_fail();
                end
                c_idx = (flit.src == NODE_ID1) ? 1 : 0;
                assert (exp_q[c_idx].size() != 0) else begin
                    $display("flit arrived from source %0d with none expected", flit.src);
                    stop_with_fail();
                end
                e = exp_q[c_idx].pop_front();
                check_eq("flit_o.data", flit.data, e.data);
                check_eq("flit_o.last", 64'(flit.last), 64'(e.last));
            end
            rnd = $random(seed);
            flit_ready <= rnd[0] | rnd[1];
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles", cycle_cnt);
            $display("** FAIL **");
            $fatal(1, "run did not finish");
        end
    end

    initial begin
        apb_data_t rd;
        logic      err;
        addr_t     a0;
        addr_t     a1;
        len_t      l0;
        len_t      l1;
        logic [31:0] rnd;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        ar_ready   = '0;
        r_valid    = '0;
        r_beat[0]  = '0;
        r_beat[1]  = '0;
        flit_ready = 1'b0;
        rd_active  = '0;
        err_beat[0] = -1;
        err_beat[1] = -1;
        cycle_cnt  = 0;
        wait (arst_n);
        @(posedge clk);

        // register readback and unmapped access
        for (int c = 0; c < 2; c++) begin
            a0  = $random(seed);
            rnd = $random(seed);
            reg_write(apb_addr_t'(c * 16) + REG_SRC, a0, 1'b0);
            reg_write(apb_addr_t'(c * 16) + REG_LEN, rnd, 1'b0);
            reg_read(apb_addr_t'(c * 16) + REG_SRC, rd);
            check_eq("prdata_o", 64'(rd), 64'(a0));
            reg_read(apb_addr_t'(c * 16) + REG_LEN, rd);
            check_eq("prdata_o", 64'(rd), 64'(rnd[3:0]));
        end
        apb_xfer(1'b0, 12'h020, '0, rd, err);
        assert (err && rd == '0) else begin
            $display("unmapped read gave no pslverr or nonzero data");
            stop_with_fail();
        end
        apb_xfer(1'b1, 12'h002, 32'hffff_ffff, rd, err);
        assert (err) else begin
            $display("unmapped write gave no pslverr");
            stop_with_fail();
        end

        // single transfer on channel 0
        rnd = $random(seed);
        start_dma(0, rand_addr(), rnd[3:0]);
        wait_done(0, 32'h2);
        wait_drained();
        reg_write(REG_STATUS, 32'h2, 1'b0);

        // both channels at once, with a refused start while busy
        for (int i = 0; i < N_CONC; i++) begin
            rnd = $random(seed);
            a0  = rand_addr();
            a1  = rand_addr();
            l0  = rnd[3:0];
            l1  = rnd[7:4];
            start_dma(0, a0, l0);
            // channel 0 cannot finish within the next apb write
            if (i == 0) begin
                reg_write(REG_CTRL, 32'h1, 1'b1);
            end
            start_dma(1, a1, l1);
            wait_done(0, 32'h2);
            wait_done(1, 32'h2);
            wait_drained();
            reg_write(REG_STATUS, 32'h2, 1'b0);
            reg_write(CH_STRIDE + REG_STATUS, 32'h2, 1'b0);
            @(negedge clk);
            check_eq("irq_o", 64'(irq), 64'h0);
        end

        // injected slverr still yields its flit
        rnd = $random(seed);
        l1  = rnd[3:0];
        err_beat[1] = int'(rnd[7:4]) % (int'(l1) + 1);
        start_dma(1, rand_addr(), l1);
        wait_done(1, 32'h6);
        wait_drained();
        err_beat[1] = -1;
        reg_write(CH_STRIDE + REG_STATUS, 32'h2, 1'b0);
        reg_read(CH_STRIDE + REG_STATUS, rd);
        check_eq("prdata_o", 64'(rd), 64'h0);

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/cluster_pkg.sv
src/apb_dma_regs.sv
src/data_dma_channel.sv
src/flit_merge.sv
src/dma_cluster_top.sv
test/tb_clk_gen.sv
test/dma_cluster_asserts.sv
test/tb_dma_cluster.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_dma_cluster \
    -f vlog.f \
    -o sim_dma_cluster

./obj_dir/sim_dma_cluster | tee sim.log

if grep -Fqx "** PASS **" sim.log; then
    exit 0
else
    exit 1
fi
